// File: sources.f
src/match_pkg.sv
src/byte_filter.sv
src/hash_bank.sv
src/hash_table.sv
src/result_align.sv
src/match_frontend.sv
testbench/tb_match_frontend.sv

// File: Makefile
TOP := tb_match_frontend

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o sim
	./obj_dir/sim > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Some tests failed" sim.log; then echo "FAIL"; exit 1; fi
	@if ! grep -q "All tests passed" sim.log; then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_match_frontend.sv
`timescale 1ns/1ps

module tb_match_frontend;
  import match_pkg::*;

  localparam int RAND_FLITS      = 200;
  localparam int CFG_WRITES      = 6;
  localparam int DIRECTED_CYCLES = 40;
  localparam int TIMEOUT_CYCLES  = CFG_WRITES + DIRECTED_CYCLES + RAND_FLITS + 100;

  logic              clk;
  logic              rst_n;
  logic [DATA_W-1:0] in_data;
  logic              in_valid;
  logic              in_last;
  logic              init;
  cfg_op_t           cfg_op;
  logic [7:0]        cfg_addr;
  rid_t              cfg_data;
  logic [LANES-1:0]  match_valid;
  rid_t [LANES-1:0]  match_rid;
  logic              pkt_done;

  integer     seed;
  int         cycle_count = 0;
  logic [7:0] pool [5];

  // shadow tables and reference state
  mask_t                  mask_sh [256];
  rid_t                   rid_sh [256];
  logic                   vld_sh [256];
  mask_t                  hist;
  logic [23:0]            tail;
  logic [FRONT_LAT-1:0][LANES-1:0]  mv_pipe;
  logic [FRONT_LAT-1:0][DATA_W-1:0] rid_pipe;
  logic [FRONT_LAT-1:0][DATA_W-1:0] rmask_pipe;
  logic [FRONT_LAT:0]               done_pipe;

  match_frontend i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_data     (in_data),
    .in_valid    (in_valid),
    .in_last     (in_last),
    .init        (init),
    .cfg_op      (cfg_op),
    .cfg_addr    (cfg_addr),
    .cfg_data    (cfg_data),
    .match_valid (match_valid),
    .match_rid   (match_rid),
    .pkt_done    (pkt_done)
  );

  always #2 clk = ~clk;

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic drive(input logic valid, input logic [DATA_W-1:0] data, input logic last,
                       input logic ini, input cfg_op_t op, input logic [7:0] addr,
                       input rid_t wdata);
    @(negedge clk);
    in_valid = valid;
    in_data  = data;
    in_last  = last;
    init     = ini;
    cfg_op   = op;
    cfg_addr = addr;
    cfg_data = wdata;
  endtask

  task automatic send_flit(input logic [DATA_W-1:0] data, input logic last, input logic ini);
    drive(1'b1, data, last, ini, CFG_NOP, '0, '0);
  endtask

  task automatic idle(input int n);
    repeat (n) drive(1'b0, '0, 1'b0, 1'b0, CFG_NOP, '0, '0);
  endtask

  task automatic cfg_write(input cfg_op_t op, input logic [7:0] addr, input rid_t wdata);
    drive(1'b0, '0, 1'b0, 1'b0, op, addr, wdata);
  endtask

  // mostly pattern bytes, now and then any byte
  task automatic make_random_flit(output logic [DATA_W-1:0] data);
    logic [31:0] r;
    for (int b = 0; b < LANES; b++) begin
      r = $random(seed);
      if (r[7:4] == 4'd0) begin
        data[b*BYTE_W +: BYTE_W] = r[15:8];
      end else begin
        data[b*BYTE_W +: BYTE_W] = pool[int'(r[2:0]) % 5];
      end
    end
  endtask

  // reference model, one flit per edge
  always @(posedge clk) begin
    logic [7:0]        win [PAT_LEN-1+LANES];
    logic [7:0]        idx;
    logic [LANES-1:0]  mv;
    logic [DATA_W-1:0] rid_v;
    logic [DATA_W-1:0] rid_m;
    if (!rst_n) begin
      for (int i = 0; i < 256; i++) begin
        mask_sh[i] = '1;
        vld_sh[i]  = 1'b0;
      end
      hist       = '1;
      tail       = '0;
      mv_pipe    <= '0;
      rid_pipe   <= '0;
      rmask_pipe <= '0;
      done_pipe  <= '0;
    end else begin
      if (cfg_op == CFG_FILTER) begin
        mask_sh[cfg_addr] = cfg_data[PAT_LEN-1:0];
      end
      if (cfg_op == CFG_HASH) begin
        rid_sh[cfg_addr] = cfg_data;
        vld_sh[cfg_addr] = 1'b1;
      end
      mv    = '0;
      rid_v = '0;
      rid_m = '0;
      if (init) begin
        hist = '1;
      end
      if (in_valid) begin
        for (int b = 0; b < PAT_LEN-1; b++) begin
          win[b] = tail[b*BYTE_W +: BYTE_W];
        end
        for (int b = 0; b < LANES; b++) begin
          win[b+PAT_LEN-1] = in_data[b*BYTE_W +: BYTE_W];
        end
        for (int l = 0; l < LANES; l++) begin
          hist  = (hist << 1) | mask_sh[win[l+PAT_LEN-1]];
          idx   = win[l] ^ win[l+1] ^ win[l+2] ^ win[l+3];
          mv[l] = vld_sh[idx] & ~hist[PAT_LEN-1];
          if (mv[l]) begin
            rid_v[l*BYTE_W +: BYTE_W] = rid_sh[idx];
            rid_m[l*BYTE_W +: BYTE_W] = '1;
          end
        end
        tail = in_last ? '0 : in_data[DATA_W-1:BYTE_W];
        if (in_last) begin
          hist = '1;
        end
      end
      mv_pipe    <= {mv_pipe[FRONT_LAT-2:0], mv};
      rid_pipe   <= {rid_pipe[FRONT_LAT-2:0], rid_v};
      rmask_pipe <= {rmask_pipe[FRONT_LAT-2:0], rid_m};
      done_pipe  <= {done_pipe[FRONT_LAT-1:0], in_valid & in_last};
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) match_valid == mv_pipe[FRONT_LAT-1])
    else stop_with_failure($sformatf("mismatch match_valid: got %h expected %h",
                                     $sampled(match_valid), $sampled(mv_pipe[FRONT_LAT-1])));

  assert property (@(posedge clk) disable iff (!rst_n)
    (match_rid & rmask_pipe[FRONT_LAT-1]) == rid_pipe[FRONT_LAT-1])
    else stop_with_failure($sformatf("mismatch match_rid: got %h expected %h",
                                     $sampled(match_rid & rmask_pipe[FRONT_LAT-1]),
                                     $sampled(rid_pipe[FRONT_LAT-1])));

  assert property (@(posedge clk) disable iff (!rst_n) pkt_done == done_pipe[FRONT_LAT])
    else stop_with_failure($sformatf("mismatch pkt_done: got %h expected %h",
                                     $sampled(pkt_done), $sampled(done_pipe[FRONT_LAT])));

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_with_failure("timeout, the run did not finish within the cycle limit");
    end
  end

  initial begin
    logic [DATA_W-1:0] data;
    logic [31:0]       r;
    seed     = 14474;
    pool     = '{8'h61, 8'h62, 8'h63, 8'h64, 8'h78};
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_data  = '0;
    in_valid = 1'b0;
    in_last  = 1'b0;
    init     = 1'b0;
    cfg_op   = CFG_NOP;
    cfg_addr = '0;
    cfg_data = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // empty tables, only pkt_done expected
    send_flit(32'h64636261, 1'b0, 1'b0);
    send_flit(32'h01020304, 1'b1, 1'b0);
    send_flit(32'h64636261, 1'b1, 1'b0);
    idle(2);
    send_flit(32'h0a0b0c0d, 1'b0, 1'b0);
    send_flit(32'h62616463, 1'b1, 1'b0);
    idle(FRONT_LAT + 2);

    // pattern "abcd" plus 'x' allowed at position 0
    cfg_write(CFG_FILTER, 8'h61, 8'h0e);
    cfg_write(CFG_FILTER, 8'h62, 8'h0d);
    cfg_write(CFG_FILTER, 8'h63, 8'h0b);
    cfg_write(CFG_FILTER, 8'h64, 8'h07);
    cfg_write(CFG_FILTER, 8'h78, 8'h0e);
    cfg_write(CFG_HASH, 8'h04, 8'h2a);

    send_flit(32'h64636261, 1'b1, 1'b0);
    // split over two flits with a gap
    send_flit(32'h62612211, 1'b0, 1'b0);
    idle(3);
    send_flit(32'h44336463, 1'b1, 1'b0);
    // "dcba" collides on the index, "xbcd" has no entry
    send_flit(32'h61626364, 1'b1, 1'b0);
    send_flit(32'h64636278, 1'b1, 1'b0);
    // split by a packet end, then by init
    send_flit(32'h62612211, 1'b1, 1'b0);
    idle(2);
    send_flit(32'h44336463, 1'b1, 1'b0);
    send_flit(32'h62612211, 1'b0, 1'b0);
    drive(1'b0, '0, 1'b0, 1'b1, CFG_NOP, '0, '0);
    send_flit(32'h44336463, 1'b1, 1'b0);
    send_flit(32'h62612211, 1'b0, 1'b0);
    send_flit(32'h44336463, 1'b1, 1'b1);
    idle(2);

    for (int n = 0; n < RAND_FLITS; n++) begin
      make_random_flit(data);
      r = $random(seed);
      send_flit(data, r[2:0] == 3'd0, r[7:4] == 4'd0);
    end
    idle(FRONT_LAT + 2);

    $display("All tests passed");
    $finish;
  end

endmodule

// File: src/match_frontend.sv
`timescale 1ns/1ps

module match_frontend (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [match_pkg::DATA_W-1:0]            in_data,
  input  logic                                    in_valid,
  input  logic                                    in_last,
  input  logic                                    init,
  input  match_pkg::cfg_op_t                      cfg_op,
  input  logic [7:0]                              cfg_addr,
  input  match_pkg::rid_t                         cfg_data,
  output logic [match_pkg::LANES-1:0]             match_valid,
  output match_pkg::rid_t [match_pkg::LANES-1:0]  match_rid,
  output logic                                    pkt_done
);
  import match_pkg::*;

  logic [LANES-1:0]        filt_pass;
  logic                    filt_valid;
  logic [LANES-1:0]        hash_hit;
  rid_t [LANES-1:0]        hash_rid;
  logic                    hash_valid;

  byte_filter i_filter (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_last    (in_last),
    .init       (init),
    .cfg_op     (cfg_op),
    .cfg_addr   (cfg_addr),
    .cfg_data   (cfg_data),
    .filt_pass  (filt_pass),
    .filt_valid (filt_valid)
  );

  hash_table i_hash (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_last    (in_last),
    .cfg_op     (cfg_op),
    .cfg_addr   (cfg_addr),
    .cfg_data   (cfg_data),
    .hash_hit   (hash_hit),
    .hash_rid   (hash_rid),
    .hash_valid (hash_valid)
  );

  result_align i_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .filt_pass   (filt_pass),
    .filt_valid  (filt_valid),
    .hash_hit    (hash_hit),
    .hash_rid    (hash_rid),
    .hash_valid  (hash_valid),
    .in_last     (in_last),
    .in_valid    (in_valid),
    .match_valid (match_valid),
    .match_rid   (match_rid),
    .pkt_done    (pkt_done)
  );

endmodule

// File: src/result_align.sv
`timescale 1ns/1ps

module result_align (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [match_pkg::LANES-1:0]             filt_pass,
  input  logic                                    filt_valid,
  input  logic [match_pkg::LANES-1:0]             hash_hit,
  input  match_pkg::rid_t [match_pkg::LANES-1:0]  hash_rid,
  input  logic                                    hash_valid,
  input  logic                                    in_last,
  input  logic                                    in_valid,
  output logic [match_pkg::LANES-1:0]             match_valid,
  output match_pkg::rid_t [match_pkg::LANES-1:0]  match_rid,
  output logic                                    pkt_done
);
  import match_pkg::*;

  logic [LANES-1:0] pass_d [HASH_LAT-FILTER_LAT];
  logic             fvld_d [HASH_LAT-FILTER_LAT];
  logic [FRONT_LAT:0] mark;

  // filter bits wait for the slower hash path
  always_ff @(posedge clk) begin
    pass_d[0] <= filt_pass;
    for (int i = 1; i < HASH_LAT-FILTER_LAT; i++) begin
      pass_d[i] <= pass_d[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < HASH_LAT-FILTER_LAT; i++) begin
        fvld_d[i] <= 1'b0;
      end
    end else begin
      fvld_d[0] <= filt_valid;
      for (int i = 1; i < HASH_LAT-FILTER_LAT; i++) begin
        fvld_d[i] <= fvld_d[i-1];
      end
    end
  end

  // filter vetoes hash collisions
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      match_valid <= '0;
    end else if (hash_valid && fvld_d[HASH_LAT-FILTER_LAT-1]) begin
      match_valid <= hash_hit & pass_d[HASH_LAT-FILTER_LAT-1];
    end else begin
      match_valid <= '0;
    end
  end

  always_ff @(posedge clk) begin
    match_rid <= hash_rid;
  end

  // end marker trails the last flit's results by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mark <= '0;
    end else begin
      mark <= {mark[FRONT_LAT-1:0], in_valid & in_last};
    end
  end

  assign pkt_done = mark[FRONT_LAT];

  assert property (@(posedge clk) disable iff (!rst_n)
    fvld_d[HASH_LAT-FILTER_LAT-1] == hash_valid)
    else $error("filter and hash pipelines out of step");

endmodule

// File: src/hash_table.sv
`timescale 1ns/1ps

module hash_table (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic [match_pkg::DATA_W-1:0]                in_data,
  input  logic                                        in_valid,
  input  logic                                        in_last,
  input  match_pkg::cfg_op_t                          cfg_op,
  input  logic [7:0]                                  cfg_addr,
  input  match_pkg::rid_t                             cfg_data,
  output logic [match_pkg::LANES-1:0]                 hash_hit,
  output match_pkg::rid_t [match_pkg::LANES-1:0]      hash_rid,
  output logic                                        hash_valid
);
  import match_pkg::*;

  logic [(PAT_LEN-1)*BYTE_W-1:0]        tail;
  logic [DATA_W+(PAT_LEN-1)*BYTE_W-1:0] ext;
  logic [PAT_LEN*BYTE_W-1:0]            win_r [LANES];
  logic                                 win_vld;
  logic [HASH_W-1:0]                    idx_c [LANES];
  logic [HASH_W-1:0]                    idx_r [LANES];
  logic                                 idx_vld;
  logic                                 wr_en;

  // oldest bytes sit in the low end
  assign ext   = {in_data, tail};
  assign wr_en = (cfg_op == CFG_HASH);

  // last three bytes of the stream, zero at packet start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tail <= '0;
    end else if (in_valid) begin
      tail <= in_last ? '0 : in_data[DATA_W-1 -: (PAT_LEN-1)*BYTE_W];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_vld <= 1'b0;
      for (int l = 0; l < LANES; l++) begin
        win_r[l] <= '0;
      end
    end else begin
      win_vld <= in_valid;
      if (in_valid) begin
        for (int l = 0; l < LANES; l++) begin
          win_r[l] <= ext[l*BYTE_W +: PAT_LEN*BYTE_W];
        end
      end
    end
  end

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      idx_c[l] = '0;
      for (int b = 0; b < PAT_LEN; b++) begin
        idx_c[l] = idx_c[l] ^ win_r[l][b*BYTE_W +: BYTE_W];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idx_vld    <= 1'b0;
      hash_valid <= 1'b0;
      for (int l = 0; l < LANES; l++) begin
        idx_r[l] <= '0;
      end
    end else begin
      idx_vld    <= win_vld;
      hash_valid <= idx_vld;
      for (int l = 0; l < LANES; l++) begin
        idx_r[l] <= idx_c[l];
      end
    end
  end

  // one bank per lane, all written together
  for (genvar l = 0; l < LANES; l++) begin : g_bank
    hash_bank i_bank (
      .clk    (clk),
      .rst_n  (rst_n),
      .rd_idx (idx_r[l]),
      .wr_en  (wr_en),
      .wr_idx (cfg_addr),
      .wr_rid (cfg_data),
      .hit    (hash_hit[l]),
      .rid    (hash_rid[l])
    );
  end

endmodule

// File: src/hash_bank.sv
`timescale 1ns/1ps

module hash_bank (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [match_pkg::HASH_W-1:0]  rd_idx,
  input  logic                          wr_en,
  input  logic [match_pkg::HASH_W-1:0]  wr_idx,
  input  match_pkg::rid_t               wr_rid,
  output logic                          hit,
  output match_pkg::rid_t               rid
);
  import match_pkg::*;

  rid_t                rid_tbl [2**HASH_W];
  logic [2**HASH_W-1:0] vld_tbl;

  // rule ids, no key stored
  always_ff @(posedge clk) begin
    if (wr_en) begin
      rid_tbl[wr_idx] <= wr_rid;
    end
    rid <= rid_tbl[rd_idx];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_tbl <= '0;
      hit     <= 1'b0;
    end else begin
      if (wr_en) begin
        vld_tbl[wr_idx] <= 1'b1;
      end
      hit <= vld_tbl[rd_idx];
    end
  end

  // index from the window pipeline must stay known
  assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(hit))
    else $error("hash bank hit is unknown");

endmodule

// File: src/byte_filter.sv
`timescale 1ns/1ps

module byte_filter (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [match_pkg::DATA_W-1:0]  in_data,
  input  logic                          in_valid,
  input  logic                          in_last,
  input  logic                          init,
  input  match_pkg::cfg_op_t            cfg_op,
  input  logic [7:0]                    cfg_addr,
  input  match_pkg::rid_t               cfg_data,
  output logic [match_pkg::LANES-1:0]   filt_pass,
  output logic                          filt_valid
);
  import match_pkg::*;

  mask_t            mask_tbl [2**BYTE_W];
  mask_t            mask_r [LANES];
  logic             valid_r;
  logic             last_r;
  logic             init_r;
  mask_t            hist;
  mask_t            hist_c;
  logic [LANES-1:0] pass_c;

  // all ones: byte fits no position
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**BYTE_W; i++) begin
        mask_tbl[i] <= '1;
      end
    end else if (cfg_op == CFG_FILTER) begin
      mask_tbl[cfg_addr] <= cfg_data[PAT_LEN-1:0];
    end
  end

  // stage 1, mask lookup per lane
  always_ff @(posedge clk) begin
    for (int l = 0; l < LANES; l++) begin
      mask_r[l] <= mask_tbl[in_data[l*BYTE_W +: BYTE_W]];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_r <= 1'b0;
      last_r  <= 1'b0;
      init_r  <= 1'b0;
    end else begin
      valid_r <= in_valid;
      last_r  <= in_valid & in_last;
      init_r  <= init;
    end
  end

  // shift-or through the lanes, lane 0 first
  always_comb begin
    hist_c = init_r ? '1 : hist;
    for (int l = 0; l < LANES; l++) begin
      hist_c    = (hist_c << 1) | mask_r[l];
      pass_c[l] = ~hist_c[PAT_LEN-1];
    end
  end

  // stage 2
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hist       <= '1;
      filt_pass  <= '0;
      filt_valid <= 1'b0;
    end else begin
      filt_valid <= valid_r;
      filt_pass  <= valid_r ? pass_c : '0;
      if (valid_r) begin
        hist <= last_r ? '1 : hist_c;
      end else if (init_r) begin
        hist <= '1;
      end
    end
  end

  // tables are only reprogrammed between flits
  assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> cfg_op == CFG_NOP)
    else $error("config write while in_valid is high");

endmodule

// File: src/match_pkg.sv
package match_pkg;

  // data path
  localparam int LANES  = 4;
  localparam int BYTE_W = 8;
  localparam int DATA_W = LANES * BYTE_W;

  // pattern and rule sizes
  localparam int PAT_LEN = 4;
  localparam int RID_W   = 8;
  localparam int HASH_W  = 8;

  // pipeline depths, in cycles from input edge
  localparam int FILTER_LAT = 2;
  localparam int HASH_LAT   = 3;
  localparam int FRONT_LAT  = 4;

  typedef logic [RID_W-1:0] rid_t;

  // bit k low: byte allowed at pattern position k
  typedef logic [PAT_LEN-1:0] mask_t;

  typedef enum logic [1:0] {
    CFG_NOP    = 2'd0,
    CFG_FILTER = 2'd1,
    CFG_HASH   = 2'd2
  } cfg_op_t;

endpackage
